// ==== Makefile ====
# Verilator build and run of the vector accumulator testbench

VERILATOR ?= verilator
TOP       ?= tb_vec_stream
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference lanes, zero after reset
logic [vec_pkg::DATA_W-1:0] model_lanes [vec_pkg::NUM_LANES];
// expected result words, oldest first
beat_t exp_q [$];
// in_ready expected low while a program drains
logic exp_busy;

// one accepted instruction applied to the reference lanes
task automatic apply_instr(input vec_pkg::instr_t ins);
    beat_t b;
    for (int i = 0; i < vec_pkg::NUM_LANES; i++) begin
        if (ins.op != vec_pkg::OP_LAST && ins.mask[i]) begin
            // sums wrap at the word width
            case (ins.op)
                vec_pkg::OP_LOAD: model_lanes[i] = ins.imm;
                vec_pkg::OP_ADD:  model_lanes[i] = model_lanes[i] + ins.imm;
                default:          model_lanes[i] = model_lanes[i] ^ ins.imm;
            endcase
        end
    end
    // program end queues all four lanes in order
    if (ins.op == vec_pkg::OP_LAST) begin
        for (int i = 0; i < vec_pkg::NUM_LANES; i++) begin
            b.data = model_lanes[i];
            b.last = (i == vec_pkg::NUM_LANES - 1);
            exp_q.push_back(b);
        end
        exp_busy = 1'b1;
    end
endtask

// 1 to MAX_INSTR lane ops, then OP_LAST
task automatic gen_program(input bit first);
    vec_pkg::instr_t ins;
    logic [31:0]     r;
    int              n;
    n = 1 + int'($unsigned($random(seed)) % MAX_INSTR);
    for (int k = 0; k < n; k++) begin
        ins.op = vec_pkg::op_t'($unsigned($random(seed)) % 3);
        r = $random(seed);
        ins.mask = r[vec_pkg::NUM_LANES-1:0];
        r = $random(seed);
        ins.imm = r[vec_pkg::DATA_W-1:0];
        // first op after reset reads every zeroed lane
        if (first && k == 0) begin
            ins.op   = vec_pkg::OP_ADD;
            ins.mask = '1;
        end
        prog_q.push_back(ins);
    end
    // mask and imm of OP_LAST are ignored
    r = $random(seed);
    ins.op   = vec_pkg::OP_LAST;
    ins.mask = r[vec_pkg::NUM_LANES-1:0];
    ins.imm  = r[31:32-vec_pkg::DATA_W];
    prog_q.push_back(ins);
endtask

`endif

// ==== bench/tb_vec_stream.sv ====
`default_nettype none

// random programs against a lane model, every output beat checked
module tb_vec_stream;

    localparam int NUM_PROGS = 40;
    localparam int MAX_INSTR = 12;
    // instruction and beat slots per program, x4 for gaps and stalls
    localparam int TIMEOUT = NUM_PROGS * (MAX_INSTR + 4) * 4 + 440;

    // one expected output word
    typedef struct packed {
        logic                       last;
        logic [vec_pkg::DATA_W-1:0] data;
    } beat_t;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic                       in_ready;
    vec_pkg::instr_t            in_instr;
    logic                       out_valid;
    logic                       out_ready;
    logic [vec_pkg::DATA_W-1:0] out_data;
    logic                       out_last;

    integer          seed;
    int              cycles;
    int              errors;
    int              checks;
    int              beats;
    int              progs_done;
    // all programs back to back
    vec_pkg::instr_t prog_q [$];
    int              pos;
    logic            took_in;
    // outputs seen at the previous falling edge
    logic                       have_prev;
    logic                       prev_ready;
    logic                       prev_valid;
    logic                       prev_last;
    logic [vec_pkg::DATA_W-1:0] prev_data;

    `include "tb_model.svh"

    vec_stream_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data (out_data),
        .out_last (out_last)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic print_counts();
        $display("errors %0d, checks %0d, beats %0d, programs %0d of %0d",
                 errors, checks, beats, progs_done, NUM_PROGS);
    endtask

    // beat taken on the coming rising edge
    task automatic take_beat();
        beat_t b;
        beats++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("output beat %0d arrived with no result word expected", beats);
        end else begin
            b = exp_q.pop_front();
            check_value("out_data", out_data, b.data);
            check_value("out_last", out_last, b.last);
            if (b.last) begin
                exp_busy = 1'b0;
                progs_done++;
            end
        end
    endtask

    // outputs are settled here, inputs change only here
    task automatic step_cycle();
        @(negedge clk);
        // stalled edge, stream registers must hold
        if (have_prev && !prev_ready) begin
            check_value("out_valid", out_valid, prev_valid);
            check_value("out_data", out_data, prev_data);
            check_value("out_last", out_last, prev_last);
        end
        check_value("in_ready", in_ready, !exp_busy);
        // an offer stays up until taken
        if (!in_valid || took_in) begin
            in_valid = 1'b0;
            if (pos < prog_q.size() && ($unsigned($random(seed)) % 4) != 0) begin
                in_valid = 1'b1;
                in_instr = prog_q[pos];
            end
        end
        // sink stalls about 30% of cycles
        out_ready = ($unsigned($random(seed)) % 10) >= 3;
        took_in = in_valid && in_ready;
        if (took_in) begin
            apply_instr(in_instr);
            pos++;
        end
        if (out_valid && out_ready) begin
            take_beat();
        end
        prev_ready = out_ready;
        prev_valid = out_valid;
        prev_last  = out_last;
        prev_data  = out_data;
        have_prev  = 1'b1;
    endtask

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout, run still busy after %0d cycles", cycles);
            print_counts();
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_instr   = '0;
        out_ready  = 1'b0;
        seed       = 32'hc337888f;
        cycles     = 0;
        errors     = 0;
        checks     = 0;
        beats      = 0;
        progs_done = 0;
        pos        = 0;
        took_in    = 1'b0;
        have_prev  = 1'b0;
        exp_busy   = 1'b0;
        for (int i = 0; i < vec_pkg::NUM_LANES; i++) begin
            model_lanes[i] = '0;
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            gen_program(p == 0);
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        while (pos < prog_q.size() || exp_q.size() != 0 || exp_busy) begin
            step_cycle();
        end
        // idle tail, any stray beat is an error
        repeat (8) step_cycle();
        print_counts();
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/agu.sv ====
`default_nettype none

// index counter from ini to fin, one step per en
module agu #(
    parameter int W = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [W-1:0] ini,
    input  logic [W-1:0] fin,
    input  logic         start,
    input  logic         en,
    output logic [W-1:0] data,
    output logic         last
);

    logic [W-1:0] cnt;
    // counting in progress
    logic         run;
    logic         busy;
    // start cycle already presents ini
    logic [W-1:0] base;

    assign busy = start || run;
    assign base = start ? ini : cnt;
    assign data = base;
    // final count only while counting
    assign last = busy && (base == fin);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= ini;
            run <= 1'b0;
        end else if (busy && en) begin
            if (base == fin) begin
                run <= 1'b0;
            end else begin
                cnt <= base + 1'b1;
                run <= 1'b1;
            end
        end else if (start) begin
            cnt <= ini;
            run <= 1'b1;
        end
    end

    a_no_restart: assert property (
        @(posedge clk) disable iff (rst) !(start && run)
    );

endmodule

`default_nettype wire

// ==== logic/instr_issue.sv ====
`default_nettype none

// input stage, registers instructions and blocks input during the drain
module instr_issue (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  vec_pkg::instr_t   in_instr,
    input  logic              drain_done,
    output vec_pkg::lane_op_t lane_op,
    output logic              prog_last
);

    // high from the OP_LAST transfer until the last beat is taken
    logic            busy;
    logic            accept;
    logic            is_last;
    // issued payload
    vec_pkg::instr_t instr_q;
    logic            op_valid;

    assign in_ready = !busy;
    assign accept   = in_valid && in_ready;
    assign is_last  = (in_instr.op == vec_pkg::OP_LAST);

    // payload capture on every transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= in_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid  <= 1'b0;
            prog_last <= 1'b0;
            busy      <= 1'b0;
        end else begin
            // lane ops only for load, add and xor
            op_valid  <= accept && !is_last;
            // one-cycle marker for the stream controller
            prog_last <= accept && is_last;
            if (drain_done) begin
                busy <= 1'b0;
            end else if (accept && is_last) begin
                busy <= 1'b1;
            end
        end
    end

    assign lane_op = '{
        valid: op_valid,
        op:    instr_q.op,
        mask:  instr_q.mask,
        imm:   instr_q.imm
    };

    // the stream only drains a program that was closed here
    a_drain_when_busy: assert property (
        @(posedge clk) disable iff (rst) drain_done |-> busy
    );

endmodule

`default_nettype wire

// ==== logic/lane_array.sv ====
`default_nettype none

// four accumulators behind a two-stage pipeline, plus the result read port
module lane_array (
    input  logic                            clk,
    input  logic                            rst,
    input  vec_pkg::lane_op_t               lane_op,
    input  logic                            rd_en,
    input  logic [vec_pkg::LANE_IDX_W-1:0]  rd_idx,
    output logic [vec_pkg::DATA_W-1:0]      out_data
);

    // lane state
    logic [vec_pkg::DATA_W-1:0] lanes  [vec_pkg::NUM_LANES];
    // stage one, registered op and operands
    vec_pkg::lane_op_t          s1_op;
    logic [vec_pkg::DATA_W-1:0] s1_val [vec_pkg::NUM_LANES];
    // stage two, result and write strobe per lane
    logic [vec_pkg::DATA_W-1:0] res    [vec_pkg::NUM_LANES];
    logic [vec_pkg::NUM_LANES-1:0] wr;
    // operand seen by stage one, with bypass
    logic [vec_pkg::DATA_W-1:0] fwd    [vec_pkg::NUM_LANES];

    always_comb begin
        for (int i = 0; i < vec_pkg::NUM_LANES; i++) begin
            wr[i] = s1_op.valid && s1_op.mask[i];
            // add wraps modulo 2^16 through the word width
            case (s1_op.op)
                vec_pkg::OP_LOAD: res[i] = s1_op.imm;
                vec_pkg::OP_ADD:  res[i] = s1_val[i] + s1_op.imm;
                vec_pkg::OP_XOR:  res[i] = s1_val[i] ^ s1_op.imm;
                default:          res[i] = s1_val[i];
            endcase
            // back-to-back op on the same lane takes the value being written
            fwd[i] = wr[i] ? res[i] : lanes[i];
        end
    end

    // operand stage
    always_ff @(posedge clk) begin
        s1_op.op   <= lane_op.op;
        s1_op.mask <= lane_op.mask;
        s1_op.imm  <= lane_op.imm;
        for (int i = 0; i < vec_pkg::NUM_LANES; i++) begin
            s1_val[i] <= fwd[i];
        end
        if (rst) begin
            s1_op.valid <= 1'b0;
        end else begin
            s1_op.valid <= lane_op.valid;
        end
    end

    // writeback stage
    always_ff @(posedge clk) begin
        for (int i = 0; i < vec_pkg::NUM_LANES; i++) begin
            if (rst) begin
                lanes[i] <= '0;
            end else if (wr[i]) begin
                lanes[i] <= res[i];
            end
        end
    end

    // registered read, one word per rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_data <= lanes[rd_idx];
        end
    end

endmodule

`default_nettype wire

// ==== logic/stream_ctrl.sv ====
`default_nettype none

// sequences the four result beats after the end of a program
module stream_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            prog_last,
    input  logic                            out_ready,
    output logic                            out_valid,
    output logic                            out_last,
    output logic                            rd_en,
    output logic [vec_pkg::LANE_IDX_W-1:0]  rd_idx,
    output logic                            drain_done
);

    // delay line so the lane writes before OP_LAST land first
    logic last_d1;
    logic last_d2;
    // delayed last seen while the sink stalled
    logic pending;
    // arm condition
    logic stream_ok;
    // arm seen, agu start waits for the next ready cycle
    logic ok_held;
    logic start;
    // high for the whole stream
    logic active;
    // agu at lane NUM_LANES-1
    logic lane_final;
    logic [vec_pkg::LANE_IDX_W-1:0] idx_fin;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_d1 <= 1'b0;
            last_d2 <= 1'b0;
        end else begin
            last_d1 <= prog_last;
            last_d2 <= last_d1;
        end
    end

    assign stream_ok = (last_d2 || pending) && out_ready;

    // arming takes priority over holding
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (stream_ok) begin
            pending <= 1'b0;
        end else if (last_d2) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ok_held <= 1'b0;
        end else if (out_ready) begin
            ok_held <= stream_ok;
        end
    end

    assign start = out_ready && ok_held;

    // cleared on the read of the final lane
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (rd_en && lane_final) begin
            active <= 1'b0;
        end else if (stream_ok) begin
            active <= 1'b1;
        end
    end

    // one lane read per ready cycle of the stream
    assign rd_en   = out_ready && active;
    assign idx_fin = vec_pkg::LANE_IDX_W'(vec_pkg::NUM_LANES - 1);

    agu #(
        .W(vec_pkg::LANE_IDX_W)
    ) agu_lane (
        .clk  (clk),
        .rst  (rst),
        .ini  ('0),
        .fin  (idx_fin),
        .start(start),
        .en   (out_ready),
        .data (rd_idx),
        .last (lane_final)
    );

    // valid and last track the read one cycle later, frozen on stall
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (out_ready) begin
            out_valid <= active;
            out_last  <= active && lane_final;
        end
    end

    // final beat taken
    assign drain_done = out_valid && out_last && out_ready;

    // a program end never arms over a stream still running
    a_arm_idle: assert property (
        @(posedge clk) disable iff (rst) stream_ok |-> (!active && !out_valid)
    );

endmodule

`default_nettype wire

// ==== logic/vec_pkg.sv ====
`default_nettype none

// shared widths and types for the vector accumulator
package vec_pkg;

    // lane word width
    localparam int DATA_W = 16;

    // fixed lane count
    localparam int NUM_LANES = 4;

    // enough bits to index every lane
    localparam int LANE_IDX_W = 2;

    // instruction opcodes
    typedef enum logic [1:0] {
        OP_LOAD = 2'd0,
        OP_ADD  = 2'd1,
        OP_XOR  = 2'd2,
        // closes the program, lanes untouched
        OP_LAST = 2'd3
    } op_t;

    // one instruction as it arrives on the input port
    // mask bit i selects lane i
    typedef struct packed {
        op_t                   op;
        logic [NUM_LANES-1:0]  mask;
        logic [DATA_W-1:0]     imm;
    } instr_t;

    // issued lane operation, valid for a single cycle
    typedef struct packed {
        logic                  valid;
        op_t                   op;
        logic [NUM_LANES-1:0]  mask;
        logic [DATA_W-1:0]     imm;
    } lane_op_t;

endpackage

`default_nettype wire

// ==== logic/vec_stream_top.sv ====
`default_nettype none

// issue, lanes, then stream controller
module vec_stream_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  vec_pkg::instr_t             in_instr,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [vec_pkg::DATA_W-1:0]  out_data,
    output logic                        out_last
);

    vec_pkg::lane_op_t              lane_op;
    logic                           prog_last;
    logic                           drain_done;
    logic                           rd_en;
    logic [vec_pkg::LANE_IDX_W-1:0] rd_idx;

    instr_issue issue0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .drain_done(drain_done),
        .lane_op   (lane_op),
        .prog_last (prog_last)
    );

    lane_array lanes0 (
        .clk     (clk),
        .rst     (rst),
        .lane_op (lane_op),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .out_data(out_data)
    );

    stream_ctrl stream0 (
        .clk       (clk),
        .rst       (rst),
        .prog_last (prog_last),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_last  (out_last),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .drain_done(drain_done)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+bench
logic/vec_pkg.sv
logic/agu.sv
logic/instr_issue.sv
logic/lane_array.sv
logic/stream_ctrl.sv
logic/vec_stream_top.sv
bench/tb_vec_stream.sv
